// ==== filelist.f ====
+incdir+.
osc_pkg.sv
sampleFront.sv
chanTrigger.sv
acqControl.sv
oscTop.sv
oscTb_sva.sv
oscChecker.sv
oscTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= oscTb
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Result: PASSED

SRCS := osc_params.svh $(shell grep -v '^+' filelist.f)
BIN := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) filelist.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f filelist.f

run: $(BIN)
	$(BIN) $(RUN_ARGS) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJDIR)

// ==== oscTb.sv ====
`include "osc_params.svh"

module oscTb;

	localparam int NTEST = 5; // captures after the idle check

	logic clk_flash;
	logic arstN;
	osc_pkg::sampleSet_t adcSample;
	logic extTrig;
	logic req;
	osc_pkg::trigCfg_t trigCfg;
	osc_pkg::acqCfg_t acqCfg;
	logic wrEn;
	osc_pkg::wrBeat_t wrBeat;
	logic [`OSC_ADDR_W-1:0] trigAddr;
	logic ack;
	logic idleCheck;
	logic trigReady;
	logic [`OSC_SAMPLE_W-1:0] expStep;
	logic [`OSC_ADDR_W-1:0] expPost;
	int testNo;
	int errCount;
	logic [31:0] lfsr; // noise for ch2 and ch3
	logic [`OSC_SAMPLE_W-1:0] ramp; // ch0, one step per clock
	logic [`OSC_SAMPLE_W-1:0] ch1Level; // ch1, shaped trigger pulses

	// {triggerPoint, nSamples, downsample, useExtTrig, extTrigDelay}
	osc_pkg::acqCfg_t acqTab [1:NTEST] = '{
		{10'd8, 10'd24, 5'd0, 1'b0, 5'd0},
		{10'd5, 10'd12, 5'd3, 1'b0, 5'd0},
		{10'd4, 10'd20, 5'd0, 1'b0, 5'd0},
		{10'd6, 10'd16, 5'd1, 1'b0, 5'd0},
		{10'd3, 10'd5, 5'd0, 1'b1, 5'd12}
	};
	// {lowThresh, highThresh, risingEdge, totCount, totOnDownsample, chanMask}
	osc_pkg::trigCfg_t trigTab [1:NTEST] = '{
		{8'd100, 8'd200, 1'b1, 10'd0, 1'b0, 4'b0010},
		{8'd100, 8'd200, 1'b1, 10'd0, 1'b0, 4'b0010},
		{8'd100, 8'd200, 1'b1, 10'd6, 1'b0, 4'b0010},
		{8'd100, 8'd200, 1'b0, 10'd0, 1'b0, 4'b0010},
		{8'd100, 8'd200, 1'b0, 10'd0, 1'b0, 4'b0000}
	};
	int kindTab [1:NTEST] = '{0, 0, 1, 0, 2}; // 1 tot short then long, 2 masked then ext

	oscTop u_oscTop (.clk_flash(clk_flash), .arstN(arstN), .adcSample(adcSample),
		.extTrig(extTrig), .req(req), .trigCfg(trigCfg), .acqCfg(acqCfg), .wrEn(wrEn),
		.wrBeat(wrBeat), .trigAddr(trigAddr), .ack(ack));

	oscChecker u_oscChecker (.clk_flash(clk_flash), .adcSample(adcSample), .wrEn(wrEn),
		.wrBeat(wrBeat), .trigAddr(trigAddr), .ack(ack), .req(req), .idleCheck(idleCheck),
		.trigReady(trigReady), .expStep(expStep), .expPost(expPost), .testNo(testNo),
		.errCount(errCount));

	always #10 clk_flash = ~clk_flash;

	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // galois, taps 32 22 2 1
	endfunction

	// expected {ch0 step, post-trigger beats} for a capture
	function automatic logic [`OSC_SAMPLE_W+`OSC_ADDR_W-1:0] refExpect(osc_pkg::acqCfg_t c);
		logic [`OSC_SAMPLE_W-1:0] step;
		logic [`OSC_ADDR_W-1:0] post;
		step = 8'(32'd1 << c.downsample); // 2^downsample mod 256
		post = c.nSamples - c.triggerPoint;
		return {step, post};
	endfunction

	task automatic takeNoise(output logic [`OSC_SAMPLE_W-1:0] v);
		v = '0;
		for (int b = 0; b < 6; b++) begin // 0..63 stays under lowThresh
			lfsr = lfsrNext(lfsr);
			v[b] = lfsr[0];
		end
	endtask

	// one clock, new samples 2 units after the edge
	task automatic tick();
		logic [`OSC_SAMPLE_W-1:0] n2;
		logic [`OSC_SAMPLE_W-1:0] n3;
		@(posedge clk_flash);
		#2;
		takeNoise(n2);
		takeNoise(n3);
		adcSample.lane[0] = ramp;
		adcSample.lane[1] = ch1Level;
		adcSample.lane[2] = n2;
		adcSample.lane[3] = n3;
		ramp = ramp + 1'b1;
	endtask

	task automatic pulseCh1(input logic [7:0] level, input logic [7:0] base, input int n);
		ch1Level = level;
		repeat (n) tick();
		ch1Level = base;
	endtask

	task automatic runCapture(input int i);
		logic [`OSC_SAMPLE_W+`OSC_ADDR_W-1:0] refVal;
		logic [7:0] base;
		logic [7:0] level;
		int beats;
		trigCfg = trigTab[i];
		acqCfg = acqTab[i];
		base = trigCfg.risingEdge ? 8'd20 : 8'd150; // outside or inside the window
		level = trigCfg.risingEdge ? 8'd150 : 8'd20;
		ch1Level = base;
		refVal = refExpect(acqCfg);
		expStep = refVal[`OSC_SAMPLE_W+`OSC_ADDR_W-1:`OSC_ADDR_W];
		expPost = refVal[`OSC_ADDR_W-1:0];
		testNo = i;
		repeat (8) tick(); // detectors settle on the new baseline
		req = 1'b1;
		beats = 0;
		while (beats < int'(acqCfg.triggerPoint) + 2) begin // pre segment done, now WAITING
			tick();
			if (wrEn) begin
				beats++;
			end
		end
		if (kindTab[i] != 0) begin
			pulseCh1(level, base, 3); // too short for tot, or masked off
			repeat (40) tick();
		end
		if (kindTab[i] == 2) begin
			extTrig = 1'b1;
			tick();
			extTrig = 1'b0;
			repeat (acqCfg.extTrigDelay) tick();
		end
		trigReady = 1'b1;
		if (kindTab[i] != 2) begin
			pulseCh1(level, base, (kindTab[i] == 1) ? 15 : 4);
		end
		while (!ack) tick();
		req = 1'b0;
		while (ack) tick();
		trigReady = 1'b0;
	endtask

	// run limit from the capture lengths
	initial begin
		int limit;
		limit = 100;
		for (int i = 1; i <= NTEST; i++) begin
			limit += (int'(acqTab[i].nSamples) << acqTab[i].downsample) + 200;
		end
		#(limit * 20);
		$display("timeout: the tests did not finish within %0d clock periods", limit);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int total;
		clk_flash = 1'b0;
		arstN = 1'b0;
		adcSample = '0;
		extTrig = 1'b0;
		req = 1'b0;
		trigCfg = '0;
		acqCfg = '0;
		idleCheck = 1'b0;
		trigReady = 1'b0;
		expStep = '0;
		expPost = '0;
		testNo = 0;
		lfsr = 32'hdf62_8370;
		ramp = '0;
		ch1Level = 8'd20;
		repeat (4) tick();
		arstN = 1'b1;
		idleCheck = 1'b1;
		repeat (12) tick();
		idleCheck = 1'b0;
		for (int i = 1; i <= NTEST; i++) begin
			runCapture(i);
		end
		repeat (2) tick();
		total = errCount + u_oscTop.u_acqControl.u_sva.failCount;
		$display("tests %0d, errors %0d", NTEST + 1, total);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== oscChecker.sv ====
`include "osc_params.svh"

module oscChecker (
	input  logic clk_flash,
	input  osc_pkg::sampleSet_t adcSample, // lanes as driven into the DUT
	input  logic wrEn,
	input  osc_pkg::wrBeat_t wrBeat,
	input  logic [`OSC_ADDR_W-1:0] trigAddr,
	input  logic ack,
	input  logic req,
	input  logic idleCheck, // outputs must hold their reset values
	input  logic trigReady, // ack is allowed from here on
	input  logic [`OSC_SAMPLE_W-1:0] expStep, // ch0 difference between beats
	input  logic [`OSC_ADDR_W-1:0] expPost, // beats from trigAddr on
	input  int testNo,
	output int errCount
);

	logic haveBeat; // a beat of this capture was seen
	logic [`OSC_SAMPLE_W-1:0] lastData;
	logic [`OSC_ADDR_W-1:0] lastAddr;
	logic [`OSC_ADDR_W-1:0] postSeen;
	osc_pkg::sampleSet_t adcQ; // adc input one clock back, what the front end holds now
	logic ackQ;
	logic reqQ;
	logic wrEnQ;
	logic idleQ;
	int testErr; // errors since the last test line

	task automatic countError();
		errCount++;
		testErr++;
	endtask

	initial begin
		errCount = 0;
		testErr = 0;
		haveBeat = 1'b0;
		adcQ = '0;
		ackQ = 1'b0;
		reqQ = 1'b0;
		wrEnQ = 1'b0;
		idleQ = 1'b0;
	end

	// outputs settle after the rising edge, look half a cycle later
	always @(negedge clk_flash) begin
		if (idleCheck && (wrEn || ack || trigAddr != '0)) begin
			$display("Fail idle {wrEn,ack,trigAddr}: got %h expected %h", {wrEn, ack, trigAddr},
				{2'b00, {`OSC_ADDR_W{1'b0}}});
			countError();
		end
		if (idleQ && !idleCheck) begin
			$display("test 0: idle after reset, %0d errors", testErr);
			testErr = 0;
		end
		if (wrEn) begin
			if (wrBeat.data != adcQ) begin
				$display("Fail wrBeat.data: got %h expected %h", wrBeat.data, adcQ);
				countError();
			end
			if (haveBeat && wrBeat.data.lane[0] - lastData != expStep) begin
				$display("Fail wrBeat.data.lane[0]: got %h expected %h", wrBeat.data.lane[0],
					lastData + expStep);
				countError();
			end
			if (haveBeat && wrBeat.addr != lastAddr + 1'b1) begin
				$display("Fail wrBeat.addr: got %h expected %h", wrBeat.addr, lastAddr + 1'b1);
				countError();
			end
			haveBeat = 1'b1;
			lastData = wrBeat.data.lane[0];
			lastAddr = wrBeat.addr;
		end
		if (ack && !ackQ) begin
			postSeen = lastAddr - trigAddr + 1'b1; // ring distance, inclusive
			if (!trigReady) begin
				$display("ack rose in test %0d before its trigger was applied", testNo);
				countError();
			end
			if (!wrEnQ) begin
				$display("ack did not rise on the cycle after the last beat");
				countError();
			end
			if (postSeen != expPost) begin
				$display("Fail post beats from trigAddr %h: got %h expected %h", trigAddr,
					postSeen, expPost);
				countError();
			end
			$display("test %0d: capture done, %0d post-trigger beats, %0d errors", testNo,
				postSeen, testErr);
			testErr = 0;
		end
		if (ackQ && !reqQ && ack) begin
			$display("Fail ack after req low: got %h expected %h", ack, 1'b0);
			countError();
		end
		if (ack) begin
			haveBeat = 1'b0; // next capture starts a new beat chain
		end
		adcQ = adcSample;
		ackQ = ack;
		reqQ = req;
		wrEnQ = wrEn;
		idleQ = idleCheck;
	end

endmodule

// ==== oscTb_sva.sv ====
`include "osc_params.svh"

module oscTb_sva (
	input logic clk_flash,
	input logic arstN,
	input logic req,
	input logic ack,
	input logic wrEn,
	input logic [`OSC_ADDR_W-1:0] wrAddr // next ring address
);

	int failCount = 0; // summed into the closing line

	ackNeedsReq: assert property (@(posedge clk_flash) disable iff (!arstN)
		$rose(ack) |-> $past(req)) else begin
		failCount++;
		$error("ack rose while req was low");
	end

	reqWaitsAck: assert property (@(posedge clk_flash) disable iff (!arstN)
		$rose(req) |-> !ack) else begin
		failCount++;
		$error("req rose while ack was still high");
	end

	ackDropsAfterReq: assert property (@(posedge clk_flash) disable iff (!arstN)
		ack && !req |=> !ack) else begin
		failCount++;
		$error("ack stayed high after req went low");
	end

	ackHeldForReq: assert property (@(posedge clk_flash) disable iff (!arstN)
		$fell(ack) |-> !req) else begin
		failCount++;
		$error("ack fell while req was still high");
	end

	// idle as the host sees it, no request or capture already acknowledged
	noWriteInIdle: assert property (@(posedge clk_flash) disable iff (!arstN)
		(!req || ack) |-> !wrEn) else begin
		failCount++;
		$error("ring write strobe high outside a capture");
	end

	addrSteps: assert property (@(posedge clk_flash) disable iff (!arstN)
		wrEn |=> wrAddr == $past(wrAddr) + 1'b1) else begin
		failCount++;
		$error("ring address did not step by one after a beat");
	end

endmodule

bind acqControl oscTb_sva u_sva (
	.clk_flash (clk_flash),
	.arstN (arstN),
	.req (req),
	.ack (ack),
	.wrEn (wrEn),
	.wrAddr (wrAddr)
);

// ==== oscTop.sv ====
`include "osc_params.svh"

module oscTop (
	input  logic clk_flash,
	input  logic arstN,
	input  osc_pkg::sampleSet_t adcSample,
	input  logic extTrig,
	input  logic req,
	input  osc_pkg::trigCfg_t trigCfg,
	input  osc_pkg::acqCfg_t acqCfg,
	output logic wrEn,
	output osc_pkg::wrBeat_t wrBeat,
	output logic [`OSC_ADDR_W-1:0] trigAddr,
	output logic ack
);

	osc_pkg::sampleSet_t sample; // registered adc data
	logic dsGo;
	logic acquiring;
	logic [`OSC_NCHAN-1:0] fire;

	sampleFront u_sampleFront (
		.clk_flash (clk_flash),
		.arstN (arstN),
		.adcSample (adcSample),
		.downsample (acqCfg.downsample),
		.acquiring (acquiring),
		.sample (sample),
		.dsGo (dsGo)
	);

	// one detector per lane, all share the same settings
	for (genvar g = 0; g < `OSC_NCHAN; g++) begin : genChan
		chanTrigger u_chanTrigger (
			.clk_flash (clk_flash),
			.arstN (arstN),
			.sample (sample.lane[g]),
			.dsGo (dsGo),
			.trigCfg (trigCfg),
			.fire (fire[g])
		);
	end

	acqControl u_acqControl (
		.clk_flash (clk_flash),
		.arstN (arstN),
		.req (req),
		.fire (fire),
		.extTrig (extTrig),
		.acqCfg (acqCfg),
		.chanMask (trigCfg.chanMask),
		.sample (sample),
		.dsGo (dsGo),
		.acquiring (acquiring),
		.wrEn (wrEn),
		.wrBeat (wrBeat),
		.trigAddr (trigAddr),
		.ack (ack)
	);

endmodule

// ==== acqControl.sv ====
`include "osc_params.svh"

module acqControl (
	input  logic clk_flash,
	input  logic arstN,
	input  logic req, // host start, four-phase
	input  logic [`OSC_NCHAN-1:0] fire, // per-channel self triggers
	input  logic extTrig, // external trigger input
	input  osc_pkg::acqCfg_t acqCfg,
	input  logic [`OSC_NCHAN-1:0] chanMask,
	input  osc_pkg::sampleSet_t sample,
	input  logic dsGo,
	output logic acquiring, // decimator runs while high
	output logic wrEn, // ring write strobe
	output osc_pkg::wrBeat_t wrBeat,
	output logic [`OSC_ADDR_W-1:0] trigAddr, // first post-trigger beat
	output logic ack // capture done, four-phase
);

	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] PREACQ = 2'd1;
	localparam logic [1:0] WAITING = 2'd2;
	localparam logic [1:0] POSTACQ = 2'd3;

	logic [1:0] state;
	logic [`OSC_EXT_DLY_N-1:0] dlyLine; // bit k is extTrig k+1 clocks ago
	logic extDly; // tap picked by extTrigDelay
	logic trig; // combined trigger
	logic [`OSC_ADDR_W-1:0] wrAddr; // next ring address
	logic [`OSC_ADDR_W-1:0] segCnt; // counted pre and post beats
	logic [`OSC_ADDR_W-1:0] segNext;

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			dlyLine <= '0;
		end else begin
			dlyLine <= {dlyLine[`OSC_EXT_DLY_N-2:0], extTrig};
		end
	end

	// delays past the last tap leave the ext trigger dead
	always_comb begin
		extDly = 1'b0;
		for (int k = 0; k < `OSC_EXT_DLY_N; k++) begin
			if (acqCfg.extTrigDelay == k) begin
				extDly = dlyLine[k];
			end
		end
	end

	assign trig = (|(fire & chanMask)) | (acqCfg.useExtTrig & extDly);

	assign acquiring = state != IDLE;
	assign wrEn = acquiring & dsGo; // no back-pressure on the ring
	assign segNext = segCnt + 1'b1;

	always_comb begin
		wrBeat.addr = wrAddr;
		wrBeat.data = sample;
	end

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			state <= IDLE;
			wrAddr <= '0;
			segCnt <= '0;
			trigAddr <= '0;
			ack <= 1'b0;
		end else begin
			if (wrEn) begin
				wrAddr <= wrAddr + 1'b1; // wraps around the ring
			end
			case (state)
				IDLE: begin
					if (ack) begin
						if (!req) begin
							ack <= 1'b0; // host saw ack, close the handshake
						end
					end else if (req) begin
						segCnt <= '0;
						state <= (acqCfg.triggerPoint == '0) ? WAITING : PREACQ;
					end
				end
				PREACQ: begin
					if (dsGo) begin
						segCnt <= segNext;
						if (segNext == acqCfg.triggerPoint) begin
							state <= WAITING;
						end
					end
				end
				WAITING: begin
					// beats here are not counted, the ring just rolls
					if (trig) begin
						trigAddr <= wrEn ? wrAddr + 1'b1 : wrAddr;
						if (segCnt == acqCfg.nSamples) begin
							state <= IDLE; // no post segment asked for
							ack <= 1'b1;
						end else begin
							state <= POSTACQ;
						end
					end
				end
				POSTACQ: begin
					if (dsGo) begin
						segCnt <= segNext;
						if (segNext == acqCfg.nSamples) begin
							state <= IDLE;
							ack <= 1'b1; // high the clock after the last beat
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== chanTrigger.sv ====
`include "osc_params.svh"

module chanTrigger (
	input  logic clk_flash,
	input  logic arstN,
	input  logic [`OSC_SAMPLE_W-1:0] sample, // this channel's lane
	input  logic dsGo, // decimated sample strobe
	input  osc_pkg::trigCfg_t trigCfg,
	output logic fire // one pulse per qualified event
);

	localparam logic [`OSC_ADDR_W:0] totOne = (`OSC_ADDR_W+1)'(1);

	logic inWin; // sample inside the window, registered
	logic prevWin; // inWin one clock earlier
	logic [`OSC_ADDR_W:0] totCnt; // nonzero while timing an excursion
	logic edgeSeen; // chosen crossing this clock
	logic beyond; // still on the far side of the crossing
	logic totStep; // tot counter may advance
	logic totDone; // excursion has lasted long enough

	assign edgeSeen = trigCfg.risingEdge ? (inWin & ~prevWin) : (~inWin & prevWin);
	assign beyond = trigCfg.risingEdge ? inWin : ~inWin;
	assign totStep = ~trigCfg.totOnDownsample | dsGo;
	assign totDone = totCnt > {1'b0, trigCfg.totCount}; // extra bit so 1023 can be exceeded

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			inWin <= 1'b0;
			prevWin <= 1'b0;
			totCnt <= '0;
			fire <= 1'b0;
		end else begin
			inWin <= (sample >= trigCfg.lowThresh) && (sample <= trigCfg.highThresh);
			prevWin <= inWin;
			fire <= 1'b0;
			if (trigCfg.totCount == '0) begin
				fire <= edgeSeen; // plain edge trigger
				totCnt <= '0;
			end else if (totCnt != '0) begin
				if (totDone) begin
					fire <= 1'b1;
					totCnt <= '0; // rearm for the next edge
				end else if (totStep) begin
					// signal came back early, drop the excursion
					totCnt <= beyond ? totCnt + 1'b1 : '0;
				end
			end else if (edgeSeen) begin
				totCnt <= totOne; // start timing
			end
		end
	end

endmodule

// ==== sampleFront.sv ====
`include "osc_params.svh"

module sampleFront (
	input  logic clk_flash,
	input  logic arstN,
	input  osc_pkg::sampleSet_t adcSample, // raw flash ADC outputs
	input  logic [4:0] downsample, // decimation shift
	input  logic acquiring, // capture in progress
	output osc_pkg::sampleSet_t sample, // adc data one clock later
	output logic dsGo // decimated sample strobe
);

	localparam logic [`OSC_DS_CNT_W-1:0] dsRestart = `OSC_DS_CNT_W'(1); // loaded after a strobe

	logic [`OSC_DS_CNT_W-1:0] dsCnt; // clocks since the last strobe, starts at 1
	logic dsBit; // counter bit picked by the shift

	// single input register, pads to fabric
	always_ff @(posedge clk_flash) begin
		sample <= adcSample;
	end

	// shifts beyond the counter never strobe
	always_comb begin
		dsBit = 1'b0;
		if (downsample < `OSC_DS_CNT_W) begin
			dsBit = dsCnt[downsample];
		end
	end

	// bit n of a counter restarted at 1 is set after 2^n clocks
	assign dsGo = (downsample == 5'd0) || dsBit;

	always_ff @(posedge clk_flash or negedge arstN) begin
		if (!arstN) begin
			dsCnt <= dsRestart;
		end else if (!acquiring || dsGo) begin
			dsCnt <= dsRestart; // new phase for each capture
		end else begin
			dsCnt <= dsCnt + 1'b1;
		end
	end

endmodule

// ==== osc_pkg.sv ====
`include "osc_params.svh"

package osc_pkg;

	// one registered sample per ADC lane, lane 0 is channel 0
	typedef struct packed {
		logic [`OSC_NCHAN-1:0][`OSC_SAMPLE_W-1:0] lane;
	} sampleSet_t;

	// self-trigger settings, common to all channels
	typedef struct packed {
		logic [`OSC_SAMPLE_W-1:0] lowThresh; // window bottom, inclusive
		logic [`OSC_SAMPLE_W-1:0] highThresh; // window top, inclusive
		logic risingEdge; // 1 fires on entry to the window, 0 on exit
		logic [`OSC_ADDR_W-1:0] totCount; // time over threshold, 0 fires at the edge
		logic totOnDownsample; // count tot only on decimated samples
		logic [`OSC_NCHAN-1:0] chanMask; // channels allowed to trigger
	} trigCfg_t;

	// capture settings, held by the host for the whole handshake
	typedef struct packed {
		logic [`OSC_ADDR_W-1:0] triggerPoint; // pre-trigger beats
		logic [`OSC_ADDR_W-1:0] nSamples; // pre plus post beats
		logic [4:0] downsample; // keep 1 of 2^downsample samples
		logic useExtTrig; // let the delayed ext trigger in
		logic [4:0] extTrigDelay; // extra clocks on the ext trigger
	} acqCfg_t;

	// one ring buffer write
	typedef struct packed {
		logic [`OSC_ADDR_W-1:0] addr;
		sampleSet_t data;
	} wrBeat_t;

endpackage

// ==== osc_params.svh ====
`ifndef OSC_PARAMS_SVH
`define OSC_PARAMS_SVH

// flash ADC sample width in bits
`define OSC_SAMPLE_W 8

// scope channels, one ADC lane each
`define OSC_NCHAN 4

// ring buffer address width, 1024 beats deep
`define OSC_ADDR_W 10

// decimation counter, wide enough for a shift of 22
`define OSC_DS_CNT_W 24

// taps on the external trigger delay line
`define OSC_EXT_DLY_N 13

`endif
